//--- verilog/exe_pkg.sv
// execute stage package with data widths, operation codes and the stage structs
package exe_pkg;

    localparam int DATA_W     = 32;  // register data width
    localparam int REG_ADDR_W = 5;   // register file address width
    localparam int SHAMT_W    = 5;   // shift amount width

    // operation code handed over by decode
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_OR   = 4'd1,
        OP_AND  = 4'd2,
        OP_NOR  = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_ADD  = 4'd8,
        OP_ADDU = 4'd9,
        OP_SUB  = 4'd10,
        OP_SUBU = 4'd11,
        OP_SLT  = 4'd12,
        OP_SLTU = 4'd13,
        OP_CLZ  = 4'd14,
        OP_CLO  = 4'd15
    } alu_op_e;

    // unit whose result goes to the register file
    typedef enum logic [1:0] {
        SEL_NONE        = 2'd0,
        SEL_LOGIC_SHIFT = 2'd1,
        SEL_ARITH       = 2'd2
    } res_sel_e;

    typedef struct packed {
        alu_op_e                 op;
        logic [DATA_W-1:0]       reg_0;
        logic [DATA_W-1:0]       reg_1;
        logic                    wen;
        logic [REG_ADDR_W-1:0]   waddr;
    } exe_req_t;

    typedef struct packed {
        alu_op_e                 op;
        logic [DATA_W-1:0]       reg_0;
        logic [DATA_W-1:0]       reg_1;
        logic                    wen;
        logic [REG_ADDR_W-1:0]   waddr;
        res_sel_e                sel;      // result select for writeback
        logic                    ov_trap;  // overflow kills the write
    } exe_issue_t;

    typedef struct packed {
        logic                    wen;
        logic [REG_ADDR_W-1:0]   waddr;
        logic [DATA_W-1:0]       wdata;
    } exe_wb_t;

endpackage

//--- verilog/exe_issue.sv
// execute issue register, decodes the operation into unit controls and latches it
`timescale 1ns/1ps
module exe_issue import exe_pkg::*; (
    input  logic       i_clk    ,
    input  logic       i_arst_n ,
    input  logic       i_valid  ,
    input  exe_req_t   i_req    ,
    output logic       o_valid  ,
    output exe_issue_t o_issue
);

res_sel_e   sel;      // decoded result select
logic       ov_trap;  // signed overflow suppresses the write
exe_issue_t issue_d;  // next issued operation

// operation -> unit select
always_comb begin
    sel     = SEL_NONE;
    ov_trap = 1'b0;
    case (i_req.op)
    OP_OR, OP_AND, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA: begin
        sel = SEL_LOGIC_SHIFT;
    end
    OP_ADD, OP_SUB: begin
        sel     = SEL_ARITH;
        ov_trap = 1'b1;
    end
    OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: begin
        sel = SEL_ARITH;
    end
    default: begin
        sel = SEL_NONE;  // nop writes nothing
    end
    endcase
end

always_comb begin
    issue_d.op      = i_req.op;
    issue_d.reg_0   = i_req.reg_0;
    issue_d.reg_1   = i_req.reg_1;
    issue_d.waddr   = i_req.waddr;
    issue_d.sel     = sel;
    issue_d.ov_trap = ov_trap;
    // idle cycle or nop never reaches the register file
    issue_d.wen     = i_valid && i_req.wen && (i_req.op != OP_NOP);
end

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_valid <= 1'b0;
        o_issue <= '0;
    end else begin
        o_valid <= i_valid;
        o_issue <= issue_d;
    end
end

endmodule

//--- verilog/exe_logic_shift.sv
// logic and shift unit, bitwise ops and barrel shifts on the issued operands
`timescale 1ns/1ps
module exe_logic_shift import exe_pkg::*; (
    input  exe_issue_t        i_issue ,
    output logic [DATA_W-1:0] o_data
);

logic [SHAMT_W-1:0] shamt;      // shift amount from operand 0
logic [DATA_W-1:0]  reg_0;
logic [DATA_W-1:0]  reg_1;      // value being shifted

assign reg_0 = i_issue.reg_0;
assign reg_1 = i_issue.reg_1;
assign shamt = reg_0[SHAMT_W-1:0];

always_comb begin
    case (i_issue.op)
    OP_OR: begin
        o_data = reg_0 | reg_1;
    end
    OP_AND: begin
        o_data = reg_0 & reg_1;
    end
    OP_NOR: begin
        o_data = ~(reg_0 | reg_1);
    end
    OP_XOR: begin
        o_data = reg_0 ^ reg_1;
    end
    OP_SLL: begin
        o_data = reg_1 << shamt;
    end
    OP_SRL: begin
        o_data = reg_1 >> shamt;
    end
    OP_SRA: begin
        // arithmetic shift keeps the sign bit
        o_data = $signed(reg_1) >>> shamt;
    end
    default: begin
        o_data = '0;
    end
    endcase
end

endmodule

//--- verilog/exe_arith.sv
// arithmetic unit with add/sub and overflow, set-on-less-than and leading zero/one count
`timescale 1ns/1ps
module exe_arith import exe_pkg::*; (
    input  exe_issue_t        i_issue ,
    output logic [DATA_W-1:0] o_data  ,
    output logic              o_ovf
);

localparam int CNT_W = $clog2(DATA_W + 1);  // count reaches DATA_W

logic [DATA_W-1:0] reg_0;
logic [DATA_W-1:0] reg_1;
logic              sub_op;     // operand 1 goes in negated
logic [DATA_W-1:0] op1_comp;   // second addend
logic [DATA_W-1:0] sum;
logic              lt_signed;
logic              lt_unsigned;
logic [CNT_W-1:0]  clz_cnt;
logic [CNT_W-1:0]  clo_cnt;

// count of zeros above the highest set bit
function automatic logic [CNT_W-1:0] lead_zeros(input logic [DATA_W-1:0] val);
    logic [CNT_W-1:0] cnt;
    logic             hit;
    cnt = '0;
    hit = 1'b0;
    for (int i = DATA_W - 1; i >= 0; i--) begin
        if (val[i]) begin
            hit = 1'b1;
        end else if (!hit) begin
            cnt = cnt + 1'b1;
        end
    end
    return cnt;
endfunction

assign reg_0  = i_issue.reg_0;
assign reg_1  = i_issue.reg_1;
assign sub_op = (i_issue.op == OP_SUB) || (i_issue.op == OP_SUBU) || (i_issue.op == OP_SLT);

assign op1_comp = sub_op ? (~reg_1 + 1'b1) : reg_1;
assign sum      = reg_0 + op1_comp;

// same-sign addends with a sum of the other sign
assign o_ovf = (!reg_0[DATA_W-1] && !op1_comp[DATA_W-1] && sum[DATA_W-1]) ||
               (reg_0[DATA_W-1] && op1_comp[DATA_W-1] && !sum[DATA_W-1]);

// negative vs positive decides, otherwise the difference sign
assign lt_signed   = (reg_0[DATA_W-1] && !reg_1[DATA_W-1]) ||
                     ((reg_0[DATA_W-1] == reg_1[DATA_W-1]) && sum[DATA_W-1]);
assign lt_unsigned = reg_0 < reg_1;

assign clz_cnt = lead_zeros(reg_0);
assign clo_cnt = lead_zeros(~reg_0);   // leading ones of operand 0

always_comb begin
    case (i_issue.op)
    OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
        o_data = sum;
    end
    OP_SLT: begin
        o_data = {{(DATA_W-1){1'b0}}, lt_signed};
    end
    OP_SLTU: begin
        o_data = {{(DATA_W-1){1'b0}}, lt_unsigned};
    end
    OP_CLZ: begin
        o_data = {{(DATA_W-CNT_W){1'b0}}, clz_cnt};
    end
    OP_CLO: begin
        o_data = {{(DATA_W-CNT_W){1'b0}}, clo_cnt};
    end
    default: begin
        o_data = '0;
    end
    endcase
end

endmodule

//--- verilog/exe_writeback.sv
// execute writeback register, picks the unit result and gates the write on overflow
`timescale 1ns/1ps
module exe_writeback import exe_pkg::*; (
    input  logic              i_clk     ,
    input  logic              i_arst_n  ,
    input  logic              i_valid   ,
    input  exe_issue_t        i_issue   ,
    input  logic [DATA_W-1:0] i_ls_data ,
    input  logic [DATA_W-1:0] i_ar_data ,
    input  logic              i_ar_ovf  ,
    output logic              o_valid   ,
    output exe_wb_t           o_wb
);

logic [DATA_W-1:0] wdata;   // selected result
logic              wen;     // write enable after the overflow check

always_comb begin
    case (i_issue.sel)
    SEL_LOGIC_SHIFT: begin
        wdata = i_ls_data;
    end
    SEL_ARITH: begin
        wdata = i_ar_data;
    end
    default: begin
        wdata = '0;
    end
    endcase
end

// add/sub with signed overflow leaves the register untouched
always_comb begin
    if (i_issue.ov_trap && i_ar_ovf) begin
        wen = 1'b0;
    end else begin
        wen = i_valid && i_issue.wen;
    end
end

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_valid <= 1'b0;
        o_wb    <= '0;
    end else begin
        o_valid    <= i_valid;
        o_wb.wen   <= wen;
        o_wb.waddr <= i_issue.waddr;
        o_wb.wdata <= wdata;
    end
end

endmodule

//--- verilog/exe_top.sv
// execute stage top, issue register, two functional units and writeback register
`timescale 1ns/1ps
module exe_top import exe_pkg::*; (
    input  logic     i_clk    ,
    input  logic     i_arst_n ,
    input  logic     i_valid  ,
    input  exe_req_t i_req    ,
    output logic     o_valid  ,
    output exe_wb_t  o_wb
);

logic              issue_valid;  // first pipeline stage valid
exe_issue_t        issue;
logic [DATA_W-1:0] ls_data;      // logic/shift result
logic [DATA_W-1:0] ar_data;      // arithmetic result
logic              ar_ovf;

exe_issue u_issue (
    .i_clk    ( i_clk       ),
    .i_arst_n ( i_arst_n    ),
    .i_valid  ( i_valid     ),
    .i_req    ( i_req       ),
    .o_valid  ( issue_valid ),
    .o_issue  ( issue       )
);

exe_logic_shift u_logic_shift (
    .i_issue ( issue   ),
    .o_data  ( ls_data )
);

exe_arith u_arith (
    .i_issue ( issue   ),
    .o_data  ( ar_data ),
    .o_ovf   ( ar_ovf  )
);

exe_writeback u_writeback (
    .i_clk     ( i_clk       ),
    .i_arst_n  ( i_arst_n    ),
    .i_valid   ( issue_valid ),
    .i_issue   ( issue       ),
    .i_ls_data ( ls_data     ),
    .i_ar_data ( ar_data     ),
    .i_ar_ovf  ( ar_ovf      ),
    .o_valid   ( o_valid     ),
    .o_wb      ( o_wb        )
);

endmodule

//--- verif/tb_exe_vectors.svh
// directed execute stage vectors with the expected writeback for each row
`ifndef TB_EXE_VECTORS_SVH
`define TB_EXE_VECTORS_SVH

// columns: op, reg_0, reg_1, wen, waddr, expected wen, expected wdata
localparam int VEC_N = 31;

vec_t vec_table [VEC_N] = '{
    '{OP_OR,   32'hf0f00000, 32'h00000f0f, 1'b1, 5'd1,  1'b1, 32'hf0f00f0f},
    '{OP_AND,  32'hff00ff00, 32'h0ff00ff0, 1'b1, 5'd2,  1'b1, 32'h0f000f00},
    '{OP_NOR,  32'h0000ffff, 32'h00ff0000, 1'b1, 5'd3,  1'b1, 32'hff000000},
    '{OP_XOR,  32'haaaa5555, 32'hffff0000, 1'b1, 5'd4,  1'b1, 32'h55555555},
    '{OP_SLL,  32'h00000004, 32'h000000ff, 1'b1, 5'd5,  1'b1, 32'h00000ff0},
    '{OP_SLL,  32'h00000000, 32'h12345678, 1'b1, 5'd6,  1'b1, 32'h12345678},  // no shift
    '{OP_SRL,  32'h00000024, 32'h80000000, 1'b1, 5'd7,  1'b1, 32'h08000000},  // low bits only
    '{OP_SRA,  32'h00000008, 32'h80001234, 1'b1, 5'd8,  1'b1, 32'hff800012},
    '{OP_SRA,  32'h0000001f, 32'h40000000, 1'b1, 5'd9,  1'b1, 32'h00000000},
    // add and subtract with wrapping and overflow
    '{OP_ADDU, 32'hffffffff, 32'h00000002, 1'b1, 5'd10, 1'b1, 32'h00000001},
    '{OP_SUBU, 32'h00000000, 32'h00000001, 1'b1, 5'd11, 1'b1, 32'hffffffff},
    '{OP_ADDU, 32'h7fffffff, 32'h00000001, 1'b1, 5'd12, 1'b1, 32'h80000000},
    '{OP_SUBU, 32'h80000000, 32'h00000001, 1'b1, 5'd31, 1'b1, 32'h7fffffff},  // keeps wen
    '{OP_ADD,  32'h7fffffff, 32'h00000001, 1'b1, 5'd13, 1'b0, 32'h80000000},
    '{OP_ADD,  32'h00000005, 32'hfffffffd, 1'b1, 5'd14, 1'b1, 32'h00000002},
    '{OP_SUB,  32'h80000000, 32'h00000001, 1'b1, 5'd15, 1'b0, 32'h7fffffff},
    '{OP_SUB,  32'h0000000a, 32'h00000003, 1'b1, 5'd16, 1'b1, 32'h00000007},
    // set on less than
    '{OP_SLT,  32'hffffffff, 32'h00000001, 1'b1, 5'd17, 1'b1, 32'h00000001},
    '{OP_SLTU, 32'hffffffff, 32'h00000001, 1'b1, 5'd18, 1'b1, 32'h00000000},
    '{OP_SLT,  32'h00000003, 32'h00000005, 1'b1, 5'd19, 1'b1, 32'h00000001},
    '{OP_SLTU, 32'h00000005, 32'h00000003, 1'b1, 5'd20, 1'b1, 32'h00000000},
    '{OP_SLT,  32'h7fffffff, 32'h80000000, 1'b1, 5'd21, 1'b1, 32'h00000000},
    // leading zero and one counts
    '{OP_CLZ,  32'h00000000, 32'h00000000, 1'b1, 5'd22, 1'b1, 32'h00000020},
    '{OP_CLZ,  32'h80000000, 32'h00000000, 1'b1, 5'd23, 1'b1, 32'h00000000},
    '{OP_CLZ,  32'h00010000, 32'h00000000, 1'b1, 5'd24, 1'b1, 32'h0000000f},
    '{OP_CLZ,  32'h00000001, 32'h00000000, 1'b1, 5'd25, 1'b1, 32'h0000001f},
    '{OP_CLO,  32'hffffffff, 32'h00000000, 1'b1, 5'd26, 1'b1, 32'h00000020},
    '{OP_CLO,  32'h7fffffff, 32'h00000000, 1'b1, 5'd27, 1'b1, 32'h00000000},
    '{OP_CLO,  32'hfff00000, 32'h00000000, 1'b1, 5'd28, 1'b1, 32'h0000000c},
    // nop and a disabled write
    '{OP_NOP,  32'h12345678, 32'h9abcdef0, 1'b1, 5'd29, 1'b0, 32'h00000000},
    '{OP_OR,   32'h00000001, 32'h00000002, 1'b0, 5'd30, 1'b0, 32'h00000003}
};

`endif

//--- verif/tb_exe_top.sv
// testbench for the execute stage with directed table rows and random logic/shift rows
`timescale 1ns/1ps
module tb_exe_top import exe_pkg::*; ();

localparam int CLK_PERIOD = 20;
localparam int RST_CYCLES = 10;
localparam int RAND_N     = 32;
localparam int SEED       = 82574;

typedef struct packed {
    alu_op_e               op;
    logic [DATA_W-1:0]     reg_0;
    logic [DATA_W-1:0]     reg_1;
    logic                  wen;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  exp_wen;
    logic [DATA_W-1:0]     exp_wdata;
} vec_t;

`include "tb_exe_vectors.svh"

logic     clk = 1'b0;
logic     arst_n = 1'b0;
logic     in_valid;
exe_req_t req;
logic     out_valid;
exe_wb_t  wb;
exe_wb_t  exp_q [$];   // writebacks still in flight
int       err_cnt;

exe_top dut (
    .i_clk    ( clk       ),
    .i_arst_n ( arst_n    ),
    .i_valid  ( in_valid  ),
    .i_req    ( req       ),
    .o_valid  ( out_valid ),
    .o_wb     ( wb        )
);

initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

task automatic check_val(input string name, input logic [DATA_W-1:0] exp,
                         input logic [DATA_W-1:0] act);
    assert (act === exp) else begin
        $display("Error: %0t ns %s expected %0h got %0h", $time, name, exp, act);
        err_cnt++;
    end
endtask

// bit level model of the logic and shift rules
function automatic logic [DATA_W-1:0] model_logic_shift(input alu_op_e op,
        input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    int                sh;
    logic [DATA_W-1:0] res;
    sh  = int'(a[SHAMT_W-1:0]);
    res = '0;
    case (op)
    OP_OR:  res = a | b;
    OP_AND: res = a & b;
    OP_NOR: res = ~(a | b);
    OP_XOR: res = a ^ b;
    OP_SLL: begin
        for (int i = sh; i < DATA_W; i++)
            res[i] = b[i - sh];
    end
    OP_SRL: begin
        for (int i = 0; i < DATA_W - sh; i++)
            res[i] = b[i + sh];
    end
    OP_SRA: begin
        for (int i = 0; i < DATA_W; i++)
            res[i] = (i + sh < DATA_W) ? b[i + sh] : b[DATA_W-1];  // sign fill
    end
    default: res = '0;
    endcase
    return res;
endfunction

function automatic vec_t random_row();
    vec_t row;
    row.op        = alu_op_e'(4'($urandom_range(7, 1)));
    row.reg_0     = $urandom();
    row.reg_1     = $urandom();
    row.wen       = 1'($urandom_range(1, 0));
    row.waddr     = REG_ADDR_W'($urandom());
    row.exp_wen   = row.wen;
    row.exp_wdata = model_logic_shift(row.op, row.reg_0, row.reg_1);
    return row;
endfunction

task automatic apply_row(input vec_t row);
    exe_wb_t exp;
    @(negedge clk);
    in_valid  = 1'b1;
    req.op    = row.op;
    req.reg_0 = row.reg_0;
    req.reg_1 = row.reg_1;
    req.wen   = row.wen;
    req.waddr = row.waddr;
    exp.wen   = row.exp_wen;
    exp.waddr = row.waddr;
    exp.wdata = row.exp_wdata;
    exp_q.push_back(exp);
endtask

task automatic idle_cycles(input int n);
    repeat (n) begin
        @(negedge clk);
        in_valid = 1'b0;
    end
endtask

// scoreboard checks at the falling edge where outputs are stable
always @(negedge clk) begin
    exe_wb_t exp;
    if (!arst_n) begin
        check_val("o_valid", '0, DATA_W'(out_valid));
        check_val("o_wb.wen", '0, DATA_W'(wb.wen));
    end else if (out_valid) begin
        assert (exp_q.size() != 0) else begin
            $display("o_valid went high with no operation in flight at %0t ns", $time);
            err_cnt++;
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            check_val("o_wb.wen", DATA_W'(exp.wen), DATA_W'(wb.wen));
            check_val("o_wb.waddr", DATA_W'(exp.waddr), DATA_W'(wb.waddr));
            check_val("o_wb.wdata", exp.wdata, wb.wdata);
        end
    end else begin
        check_val("o_wb.wen", '0, DATA_W'(wb.wen));  // no write without valid
    end
end

initial begin
    #((VEC_N + RAND_N + RST_CYCLES + 20) * CLK_PERIOD);
    $display("Timeout: the run did not finish in the expected number of cycles");
    $display("errors: %0d, operations not delivered: %0d", err_cnt, exp_q.size());
    $display("Checks failed");
    $finish;
end

initial begin
    void'($urandom(SEED));
    err_cnt  = 0;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    req      = '0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    idle_cycles(2);
    for (int i = 0; i < VEC_N; i++) begin
        apply_row(vec_table[i]);  // back to back with no gaps
    end
    idle_cycles(3);
    for (int i = 0; i < RAND_N; i++) begin
        apply_row(random_row());
    end
    idle_cycles(1);
    while (exp_q.size() != 0) begin
        @(negedge clk);
    end
    idle_cycles(2);
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
        $display("All checks passed");
    end else begin
        $display("Checks failed");
    end
    $finish;
end

endmodule

//--- project.f
+incdir+verif
verilog/exe_pkg.sv
verilog/exe_issue.sv
verilog/exe_logic_shift.sv
verilog/exe_arith.sv
verilog/exe_writeback.sv
verilog/exe_top.sv
verif/tb_exe_top.sv

//--- Makefile
SRCS := $(wildcard verilog/*.sv verif/*.sv verif/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vtb_exe_top: project.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_exe_top -f project.f -o Vtb_exe_top

run: obj_dir/Vtb_exe_top
	@out="$$(./obj_dir/Vtb_exe_top)"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
